// ==== src/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

////////////////////
// Core sizes
////////////////////

// Data and address width
`define XLEN 32

// Fetch buffer depth, ring holds one less than this
`define FB_ENTRIES 4

////////////////////
// Encodings
////////////////////

// ADDI x0, x0, 0
`define NOP_INSTR 32'h0000_0013

// Major opcodes handled by decode
`define OPC_REG 7'b0110011
`define OPC_IMM 7'b0010011
`define OPC_BRANCH 7'b1100011

`endif

// ==== src/corePkg.sv ====
package corePkg;

  ////////////////////
  // Instruction views
  ////////////////////

  // Register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rFields;

  // Immediate layout
  // Branches reuse it, imm holds imm[12|10:5] and rs2, rd holds imm[4:1|11]
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } iFields;

  // One 32-bit word, two ways of reading it
  typedef union packed {
    rFields rView;
    iFields iView;
  } instrWord;

  ////////////////////
  // ALU operations
  ////////////////////

  // Branch compares share the encoding space with the arithmetic ops
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluBeq,
    aluBne
  } aluOp;

endpackage

// ==== src/fetchBuffer.sv ====
`include "core_cfg.svh"

module fetchBuffer (
  input  logic             clk,
  input  logic             reset,
  input  logic             fetchStall,
  input  logic             decodeStall,
  input  logic             flush,
  input  logic [`XLEN-1:0] fetchPc,
  input  logic [`XLEN-1:0] fetchInstr,
  output logic [`XLEN-1:0] bufferPc,
  output logic [`XLEN-1:0] bufferInstr,
  output logic             bufferFull,
  output logic             risingFull
);

  // Entry storage
  logic [`XLEN-1:0] pcReg [`FB_ENTRIES];
  logic [`XLEN-1:0] instrReg [`FB_ENTRIES];

  // One-hot pointers and their rotated copies
  logic [`FB_ENTRIES-1:0] readPtr;
  logic [`FB_ENTRIES-1:0] writePtr;
  logic [`FB_ENTRIES-1:0] readPtrRot;
  logic [`FB_ENTRIES-1:0] writePtrRot;
  logic [`FB_ENTRIES-1:0] entryEnable;

  logic empty;
  logic full;
  logic fullDelay;

  // AND-OR mux outputs before the empty fallback
  logic [`XLEN-1:0] muxPc;
  logic [`XLEN-1:0] muxInstr;

  ////////////////////
  // Status
  ////////////////////

  // Left rotate is the one-hot increment
  assign readPtrRot  = {readPtr[`FB_ENTRIES-2:0], readPtr[`FB_ENTRIES-1]};
  assign writePtrRot = {writePtr[`FB_ENTRIES-2:0], writePtr[`FB_ENTRIES-1]};

  // Pointers coincide when nothing is stored
  assign empty = |(readPtr & writePtr);
  // Next write slot would hit the read slot
  assign full  = |(writePtrRot & readPtr);

  assign bufferFull = full;
  assign risingFull = full & ~fullDelay;

  // Write slot loads unless full, first full cycle still loads
  assign entryEnable = writePtr & {`FB_ENTRIES{~full | risingFull}};

  ////////////////////
  // Pointers
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      writePtr  <= {{(`FB_ENTRIES-1){1'b0}}, 1'b1};
      readPtr   <= {{(`FB_ENTRIES-1){1'b0}}, 1'b1};
      fullDelay <= 1'b0;
    end else begin
      fullDelay <= full;
      // Held pair is rewritten in place while stalled
      if (!full && !fetchStall) begin
        writePtr <= writePtrRot;
      end
      if (!decodeStall && !empty) begin
        readPtr <= readPtrRot;
      end
    end
  end

  ////////////////////
  // Entries
  ////////////////////

  // Flush turns every slot into a no-op, pointers keep going
  always_ff @(posedge clk) begin
    for (int i = 0; i < `FB_ENTRIES; i++) begin
      if (reset || flush) begin
        pcReg[i]    <= '0;
        instrReg[i] <= `NOP_INSTR;
      end else if (entryEnable[i]) begin
        pcReg[i]    <= fetchPc;
        instrReg[i] <= fetchInstr;
      end
    end
  end

  // AND-OR read mux over the one-hot read pointer
  always_comb begin
    muxPc    = '0;
    muxInstr = '0;
    for (int i = 0; i < `FB_ENTRIES; i++) begin
      muxPc    = muxPc | (pcReg[i] & {`XLEN{readPtr[i]}});
      muxInstr = muxInstr | (instrReg[i] & {`XLEN{readPtr[i]}});
    end
  end

  // Empty ring shows a no-op at PC zero
  assign bufferPc    = empty ? '0 : muxPc;
  assign bufferInstr = empty ? `NOP_INSTR : muxInstr;

endmodule

// ==== src/decodeStage.sv ====
`include "core_cfg.svh"

module decodeStage (
  input  logic               clk,
  input  logic               reset,
  input  logic               decodeStall,
  input  logic               flush,
  input  logic [`XLEN-1:0]   bufferPc,
  input  logic [`XLEN-1:0]   bufferInstr,
  output logic               decValid,
  output corePkg::aluOp      decOp,
  output logic [4:0]         decRs1,
  output logic [4:0]         decRs2,
  output logic [4:0]         decRd,
  output logic [`XLEN-1:0]   decImm,
  output logic               decUseImm,
  output logic [`XLEN-1:0]   decPc
);
  import corePkg::*;

  instrWord         instr;
  aluOp             nextOp;
  logic             nextSupported;
  logic             nextUseImm;
  logic             isNop;
  logic [4:0]       nextRs2;
  logic [4:0]       nextRd;
  logic [`XLEN-1:0] nextImm;

  assign instr = bufferInstr;
  // Flushed and empty slots carry the no-op, treat as a bubble
  assign isNop = (bufferInstr == `NOP_INSTR);

  ////////////////////
  // Field decode
  ////////////////////

  always_comb begin
    nextOp        = aluAdd;
    nextSupported = 1'b0;
    nextUseImm    = 1'b0;
    nextRs2       = instr.rView.rs2;
    nextRd        = instr.rView.rd;
    // I view immediate, sign extended
    nextImm       = {{(`XLEN-12){instr.iView.imm[11]}}, instr.iView.imm};
    case (instr.rView.opcode)
      `OPC_REG: begin
        nextSupported = 1'b1;
        case ({instr.rView.funct7, instr.rView.funct3})
          10'b0000000_000: nextOp = aluAdd;
          10'b0100000_000: nextOp = aluSub;
          10'b0000000_100: nextOp = aluXor;
          10'b0000000_110: nextOp = aluOr;
          10'b0000000_111: nextOp = aluAnd;
          default:         nextSupported = 1'b0;
        endcase
      end
      `OPC_IMM: begin
        nextSupported = 1'b1;
        nextUseImm    = 1'b1;
        // No second source, keeps forwarding quiet
        nextRs2       = 5'd0;
        case (instr.iView.funct3)
          3'b000:  nextOp = aluAdd;
          3'b100:  nextOp = aluXor;
          3'b110:  nextOp = aluOr;
          3'b111:  nextOp = aluAnd;
          default: nextSupported = 1'b0;
        endcase
      end
      `OPC_BRANCH: begin
        nextSupported = 1'b1;
        nextRd        = 5'd0;
        // Offset bits scattered over the imm and rd fields
        nextImm = {{(`XLEN-12){instr.iView.imm[11]}}, instr.iView.rd[0],
                   instr.iView.imm[10:5], instr.iView.rd[4:1], 1'b0};
        case (instr.iView.funct3)
          3'b000:  nextOp = aluBeq;
          3'b001:  nextOp = aluBne;
          default: nextSupported = 1'b0;
        endcase
      end
      default: nextSupported = 1'b0;
    endcase
  end

  ////////////////////
  // Decode register
  ////////////////////

  // Stall and flush both drop a bubble into execute
  always_ff @(posedge clk) begin
    if (reset) begin
      decValid <= 1'b0;
    end else begin
      decValid <= nextSupported & ~isNop & ~decodeStall & ~flush;
    end
  end

  // Payload follows the buffer, qualified by decValid
  always_ff @(posedge clk) begin
    decOp     <= nextOp;
    decRs1    <= instr.rView.rs1;
    decRs2    <= nextRs2;
    decRd     <= nextRd;
    decImm    <= nextImm;
    decUseImm <= nextUseImm;
    decPc     <= bufferPc;
  end

endmodule

// ==== src/executeStage.sv ====
`include "core_cfg.svh"

module executeStage (
  input  logic               clk,
  input  logic               reset,
  input  logic               decValid,
  input  corePkg::aluOp      decOp,
  input  logic [4:0]         decRs1,
  input  logic [4:0]         decRs2,
  input  logic [4:0]         decRd,
  input  logic [`XLEN-1:0]   decImm,
  input  logic               decUseImm,
  input  logic [`XLEN-1:0]   decPc,
  input  logic [`XLEN-1:0]   rs1Data,
  input  logic [`XLEN-1:0]   rs2Data,
  output logic [4:0]         rs1Addr,
  output logic [4:0]         rs2Addr,
  output logic               redirect,
  output logic [`XLEN-1:0]   redirectPc,
  output logic               exValid,
  output logic [4:0]         exRd,
  output logic [`XLEN-1:0]   exData
);
  import corePkg::*;

  logic [`XLEN-1:0] opA;
  logic [`XLEN-1:0] rs2Value;
  logic [`XLEN-1:0] opB;
  logic [`XLEN-1:0] aluResult;
  logic             isBranch;
  logic             operandsEqual;
  logic             fwdRs1;
  logic             fwdRs2;

  ////////////////////
  // Operand read
  ////////////////////

  assign rs1Addr = decRs1;
  assign rs2Addr = decRs2;

  // Previous result still in flight, never forward x0
  assign fwdRs1 = exValid && (exRd != 5'd0) && (exRd == decRs1);
  assign fwdRs2 = exValid && (exRd != 5'd0) && (exRd == decRs2);

  assign opA      = fwdRs1 ? exData : rs1Data;
  assign rs2Value = fwdRs2 ? exData : rs2Data;
  assign opB      = decUseImm ? decImm : rs2Value;

  ////////////////////
  // ALU and branch
  ////////////////////

  always_comb begin
    case (decOp)
      aluSub:  aluResult = opA - opB;
      aluAnd:  aluResult = opA & opB;
      aluOr:   aluResult = opA | opB;
      aluXor:  aluResult = opA ^ opB;
      default: aluResult = opA + opB;
    endcase
  end

  assign isBranch      = (decOp == aluBeq) || (decOp == aluBne);
  assign operandsEqual = (opA == rs2Value);

  // Resolved in the same cycle, drives the flush upstream
  assign redirect = decValid &&
                    (((decOp == aluBeq) && operandsEqual) ||
                     ((decOp == aluBne) && !operandsEqual));
  assign redirectPc = decPc + decImm;

  ////////////////////
  // Execute-to-result register
  ////////////////////

  // Branches never reach write-back
  always_ff @(posedge clk) begin
    if (reset) begin
      exValid <= 1'b0;
    end else begin
      exValid <= decValid & ~isBranch;
    end
  end

  always_ff @(posedge clk) begin
    exRd   <= decRd;
    exData <= aluResult;
  end

endmodule

// ==== src/resultStage.sv ====
`include "core_cfg.svh"

module resultStage (
  input  logic             clk,
  input  logic             reset,
  input  logic             exValid,
  input  logic [4:0]       exRd,
  input  logic [`XLEN-1:0] exData,
  input  logic [4:0]       rs1Addr,
  input  logic [4:0]       rs2Addr,
  output logic [`XLEN-1:0] rs1Data,
  output logic [`XLEN-1:0] rs2Data,
  output logic             wbEnable,
  output logic [4:0]       wbReg,
  output logic [`XLEN-1:0] wbData
);

  localparam int RegCount = 32;

  logic [`XLEN-1:0] regFile [RegCount];

  // x0 reads zero and an in-flight write wins over the stored value
  function automatic logic [`XLEN-1:0] readPort(input logic [4:0] addr);
    logic [`XLEN-1:0] value;
    if (addr == 5'd0) begin
      value = '0;
    end else if (wbEnable && (wbReg == addr)) begin
      value = wbData;
    end else begin
      value = regFile[addr];
    end
    return value;
  endfunction

  ////////////////////
  // Write-back
  ////////////////////

  // Nothing written for bubbles, branches or x0
  assign wbEnable = exValid && (exRd != 5'd0);
  assign wbReg    = exRd;
  assign wbData   = exData;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < RegCount; i++) begin
        regFile[i] <= '0;
      end
    end else if (wbEnable) begin
      regFile[wbReg] <= wbData;
    end
  end

  // Read ports
  always_comb begin
    rs1Data = readPort(rs1Addr);
    rs2Data = readPort(rs2Addr);
  end

endmodule

// ==== src/coreTop.sv ====
`include "core_cfg.svh"

module coreTop (
  input  logic             clk,
  input  logic             reset,
  input  logic [`XLEN-1:0] fetchPc,
  input  logic [`XLEN-1:0] fetchInstr,
  input  logic             fetchStall,
  input  logic             decodeStall,
  output logic             bufferFull,
  output logic             redirect,
  output logic [`XLEN-1:0] redirectPc,
  output logic             wbEnable,
  output logic [4:0]       wbReg,
  output logic [`XLEN-1:0] wbData
);
  import corePkg::*;

  // Buffer to decode
  logic [`XLEN-1:0] bufferPc;
  logic [`XLEN-1:0] bufferInstr;

  // Decode to execute
  logic             decValid;
  aluOp             decOp;
  logic [4:0]       decRs1;
  logic [4:0]       decRs2;
  logic [4:0]       decRd;
  logic [`XLEN-1:0] decImm;
  logic             decUseImm;
  logic [`XLEN-1:0] decPc;

  // Execute and result
  logic [4:0]       rs1Addr;
  logic [4:0]       rs2Addr;
  logic [`XLEN-1:0] rs1Data;
  logic [`XLEN-1:0] rs2Data;
  logic             exValid;
  logic [4:0]       exRd;
  logic [`XLEN-1:0] exData;

  ////////////////////
  // Stages
  ////////////////////

  // Taken branch flushes the buffer and decode
  fetchBuffer u_fetchBuffer (
    .clk         (clk),
    .reset       (reset),
    .fetchStall  (fetchStall),
    .decodeStall (decodeStall),
    .flush       (redirect),
    .fetchPc     (fetchPc),
    .fetchInstr  (fetchInstr),
    .bufferPc    (bufferPc),
    .bufferInstr (bufferInstr),
    .bufferFull  (bufferFull),
    .risingFull  ()
  );

  decodeStage u_decodeStage (
    .clk         (clk),
    .reset       (reset),
    .decodeStall (decodeStall),
    .flush       (redirect),
    .bufferPc    (bufferPc),
    .bufferInstr (bufferInstr),
    .decValid    (decValid),
    .decOp       (decOp),
    .decRs1      (decRs1),
    .decRs2      (decRs2),
    .decRd       (decRd),
    .decImm      (decImm),
    .decUseImm   (decUseImm),
    .decPc       (decPc)
  );

  executeStage u_executeStage (
    .clk        (clk),
    .reset      (reset),
    .decValid   (decValid),
    .decOp      (decOp),
    .decRs1     (decRs1),
    .decRs2     (decRs2),
    .decRd      (decRd),
    .decImm     (decImm),
    .decUseImm  (decUseImm),
    .decPc      (decPc),
    .rs1Data    (rs1Data),
    .rs2Data    (rs2Data),
    .rs1Addr    (rs1Addr),
    .rs2Addr    (rs2Addr),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .exValid    (exValid),
    .exRd       (exRd),
    .exData     (exData)
  );

  resultStage u_resultStage (
    .clk      (clk),
    .reset    (reset),
    .exValid  (exValid),
    .exRd     (exRd),
    .exData   (exData),
    .rs1Addr  (rs1Addr),
    .rs2Addr  (rs2Addr),
    .rs1Data  (rs1Data),
    .rs2Data  (rs2Data),
    .wbEnable (wbEnable),
    .wbReg    (wbReg),
    .wbData   (wbData)
  );

endmodule

// ==== test/coreAsserts.sv ====
`include "core_cfg.svh"

module coreAsserts (
  input logic                   clk,
  input logic                   reset,
  input logic [`FB_ENTRIES-1:0] readPtr,
  input logic [`FB_ENTRIES-1:0] writePtr,
  input logic                   empty,
  input logic                   full,
  input logic                   risingFull
);
  timeunit 1ns;
  timeprecision 100ps;

  // Read by the testbench for the final tally
  int failCount = 0;

  ////////////////////
  // Pointer checks
  ////////////////////

  pointersOneHot: assert property (@(posedge clk) disable iff (reset)
    $onehot(readPtr) && $onehot(writePtr))
    else begin
      failCount++;
      $error("read or write pointer is not one-hot");
    end

  notFullAndEmpty: assert property (@(posedge clk) disable iff (reset)
    !(full && empty))
    else begin
      failCount++;
      $error("buffer full and empty at once");
    end

  // Write pointer frozen while full
  holdWhileFull: assert property (@(posedge clk) disable iff (reset)
    full |=> $stable(writePtr))
    else begin
      failCount++;
      $error("write pointer moved while full");
    end

  ////////////////////
  // Rising full
  ////////////////////

  risingFullOnEntry: assert property (@(posedge clk) disable iff (reset)
    $rose(full) |-> risingFull)
    else begin
      failCount++;
      $error("risingFull missing on first full cycle");
    end

  risingFullOneCycle: assert property (@(posedge clk) disable iff (reset)
    risingFull |=> !risingFull)
    else begin
      failCount++;
      $error("risingFull held longer than one cycle");
    end

endmodule

// ==== test/coreChecker.sv ====
`include "core_cfg.svh"

module coreChecker #(
  parameter int Rows = 22
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             bufferFull,
  input  logic             redirect,
  input  logic [`XLEN-1:0] redirectPc,
  input  logic             wbEnable,
  input  logic [4:0]       wbReg,
  input  logic [`XLEN-1:0] wbData,
  input  logic             rowExec [Rows],
  input  logic             rowBranch [Rows],
  input  logic             rowTaken [Rows],
  input  logic [4:0]       rowRd [Rows],
  input  logic [`XLEN-1:0] rowValue [Rows],
  input  logic [`XLEN-1:0] rowTarget [Rows],
  input  int               otherErrors,
  input  logic             report,
  output logic             done,
  output int               errorCount
);
  timeunit 1ns;
  timeprecision 100ps;

  int   cursor = 0;
  logic afterReset = 1'b0;

  // Next row that shows up on the ports: a write-back or a taken branch
  function automatic int nextEvent(input int from);
    for (int i = from; i < Rows; i++) begin
      if (rowExec[i] && (rowBranch[i] ? rowTaken[i] : (rowRd[i] != 5'd0))) begin
        return i;
      end
    end
    return Rows;
  endfunction

  assign done = !reset && (cursor >= Rows);

  ////////////////////
  // Port watch
  ////////////////////

  initial errorCount = 0;

  always @(posedge clk) begin
    if (reset) begin
      cursor     = nextEvent(0);
      afterReset = 1'b1;
    end else begin
      // Outputs idle straight out of reset
      if (afterReset && (wbEnable || redirect || bufferFull)) begin
        errorCount++;
        $display("FAIL %0t: outputs not idle after reset", $time);
      end
      afterReset = 1'b0;
      // Older instruction retires first when both fire together
      if (wbEnable) begin
        if (cursor >= Rows || rowBranch[cursor]) begin
          errorCount++;
          $display("FAIL %0t: unexpected write-back x%0d=%h", $time, wbReg, wbData);
        end else begin
          if (wbReg != rowRd[cursor] || wbData != rowValue[cursor]) begin
            errorCount++;
            $display("FAIL %0t: row %0d expected x%0d=%h, got x%0d=%h", $time,
                     cursor, rowRd[cursor], rowValue[cursor], wbReg, wbData);
          end
          cursor = nextEvent(cursor + 1);
        end
      end
      if (redirect) begin
        if (cursor >= Rows || !rowBranch[cursor]) begin
          errorCount++;
          $display("FAIL %0t: unexpected redirect to %h", $time, redirectPc);
        end else begin
          if (redirectPc != rowTarget[cursor]) begin
            errorCount++;
            $display("FAIL %0t: row %0d redirect expected %h, got %h", $time,
                     cursor, rowTarget[cursor], redirectPc);
          end
          cursor = nextEvent(cursor + 1);
        end
      end
    end
  end

  // Closing tally
  always @(posedge report) begin
    $display("Errors: %0d mismatches, %0d other", errorCount, otherErrors);
  end

endmodule

// ==== test/coreTb.sv ====
`include "core_cfg.svh"

module coreTb;
  timeunit 1ns;
  timeprecision 100ps;
  import corePkg::*;

  localparam int Rows = 22;
  localparam int WaitLimit = 3000;
  localparam logic [`XLEN-1:0] BasePc = 32'h0000_0100;

  logic             clk;
  logic             reset;
  logic [`XLEN-1:0] fetchPc;
  logic [`XLEN-1:0] fetchInstr;
  logic             fetchStall;
  logic             decodeStall;
  logic             bufferFull;
  logic             redirect;
  logic [`XLEN-1:0] redirectPc;
  logic             wbEnable;
  logic [4:0]       wbReg;
  logic [`XLEN-1:0] wbData;

  // Program table with one row per PC step of 4
  instrWord         rowInstr [Rows];
  logic             rowExec [Rows];
  logic             rowBranch [Rows];
  logic             rowTaken [Rows];
  logic [4:0]       rowRd [Rows];
  logic [`XLEN-1:0] rowValue [Rows];
  logic [`XLEN-1:0] rowTarget [Rows];

  logic             done;
  logic             report;
  int               errorCount;
  int               otherErrors;
  int               waitErrors;
  logic [`XLEN-1:0] pcNow;
  logic             accepted;

  coreTop u_dut (
    .clk         (clk),
    .reset       (reset),
    .fetchPc     (fetchPc),
    .fetchInstr  (fetchInstr),
    .fetchStall  (fetchStall),
    .decodeStall (decodeStall),
    .bufferFull  (bufferFull),
    .redirect    (redirect),
    .redirectPc  (redirectPc),
    .wbEnable    (wbEnable),
    .wbReg       (wbReg),
    .wbData      (wbData)
  );

  bind fetchBuffer coreAsserts u_asserts (
    .clk        (clk),
    .reset      (reset),
    .readPtr    (readPtr),
    .writePtr   (writePtr),
    .empty      (empty),
    .full       (full),
    .risingFull (risingFull)
  );

  coreChecker #(.Rows(Rows)) u_checker (
    .clk(clk), .reset(reset), .bufferFull(bufferFull), .redirect(redirect),
    .redirectPc(redirectPc), .wbEnable(wbEnable), .wbReg(wbReg), .wbData(wbData),
    .rowExec(rowExec), .rowBranch(rowBranch), .rowTaken(rowTaken), .rowRd(rowRd),
    .rowValue(rowValue), .rowTarget(rowTarget), .otherErrors(otherErrors),
    .report(report), .done(done), .errorCount(errorCount)
  );

  ////////////////////
  // Encoders
  ////////////////////

  function automatic instrWord rType(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
    instrWord w;
    w.rView = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: `OPC_REG};
    return w;
  endfunction

  function automatic instrWord iType(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd);
    instrWord w;
    w.iView = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: `OPC_IMM};
    return w;
  endfunction

  // Branch offset bits scattered into the imm and rd fields
  function automatic instrWord bType(input logic [12:0] off, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
    instrWord w;
    w.iView = '{imm: {off[12], off[10:5], rs2}, rs1: rs1, funct3: f3,
                rd: {off[4:1], off[11]}, opcode: `OPC_BRANCH};
    return w;
  endfunction

  task automatic setRow(input int idx, input instrWord w, input logic exec,
                        input logic [4:0] rd, input logic [`XLEN-1:0] value);
    rowInstr[idx]  = w;
    rowExec[idx]   = exec;
    rowBranch[idx] = 1'b0;
    rowTaken[idx]  = 1'b0;
    rowRd[idx]     = rd;
    rowValue[idx]  = value;
    rowTarget[idx] = '0;
  endtask

  task automatic setBranch(input int idx, input instrWord w, input logic taken,
                           input int targetRow);
    setRow(idx, w, 1'b1, 5'd0, '0);
    rowBranch[idx] = 1'b1;
    rowTaken[idx]  = taken;
    rowTarget[idx] = BasePc + 4 * targetRow;
  endtask

  ////////////////////
  // Program
  ////////////////////

  task automatic buildTable();
    setRow(0, iType(12'd5, 5'd0, 3'b000, 5'd1), 1, 5'd1, 32'd5);
    setRow(1, iType(-12'sd3, 5'd0, 3'b000, 5'd2), 1, 5'd2, 32'hFFFF_FFFD);
    // Back-to-back dependents exercise forwarding
    setRow(2, rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1, 5'd3, 32'd2);
    setRow(3, rType(7'h20, 5'd1, 5'd3, 3'b000, 5'd4), 1, 5'd4, 32'hFFFF_FFFD);
    setRow(4, rType(7'h00, 5'd1, 5'd4, 3'b111, 5'd5), 1, 5'd5, 32'd5);
    setRow(5, rType(7'h00, 5'd2, 5'd5, 3'b110, 5'd6), 1, 5'd6, 32'hFFFF_FFFD);
    setRow(6, rType(7'h00, 5'd1, 5'd6, 3'b100, 5'd7), 1, 5'd7, 32'hFFFF_FFF8);
    setRow(7, iType(12'h0F0, 5'd7, 3'b111, 5'd8), 1, 5'd8, 32'h0000_00F0);
    setRow(8, iType(12'h00F, 5'd8, 3'b110, 5'd9), 1, 5'd9, 32'h0000_00FF);
    setRow(9, iType(12'hFFF, 5'd9, 3'b100, 5'd10), 1, 5'd10, 32'hFFFF_FF00);
    // Write to x0 is dropped, then x0 reads back as zero
    setRow(10, iType(12'd7, 5'd1, 3'b000, 5'd0), 1, 5'd0, '0);
    setRow(11, rType(7'h00, 5'd1, 5'd0, 3'b000, 5'd11), 1, 5'd11, 32'd5);
    setBranch(12, bType(13'd12, 5'd11, 5'd1, 3'b000), 1, 15);
    setRow(13, iType(12'd99, 5'd0, 3'b000, 5'd12), 0, 5'd12, 32'd99);
    setRow(14, iType(12'd98, 5'd0, 3'b000, 5'd13), 0, 5'd13, 32'd98);
    setBranch(15, bType(13'd8, 5'd11, 5'd1, 3'b001), 0, 17);
    setRow(16, iType(12'd1, 5'd1, 3'b000, 5'd14), 1, 5'd14, 32'd6);
    setBranch(17, bType(13'd8, 5'd1, 5'd14, 3'b001), 1, 19);
    setRow(18, iType(12'd1, 5'd0, 3'b000, 5'd15), 0, 5'd15, 32'd1);
    setRow(19, rType(7'h00, 5'd3, 5'd14, 3'b100, 5'd16), 1, 5'd16, 32'd4);
    setRow(20, rType(7'h20, 5'd16, 5'd16, 3'b000, 5'd17), 1, 5'd17, 32'd0);
    setRow(21, iType(12'hFFF, 5'd17, 3'b000, 5'd18), 1, 5'd18, 32'hFFFF_FFFF);
  endtask

  // Past the table end the source keeps feeding no-ops
  function automatic logic [`XLEN-1:0] instrAt(input logic [`XLEN-1:0] pc);
    logic [`XLEN-1:0] idx;
    idx = (pc - BasePc) >> 2;
    if (pc < BasePc || idx >= Rows) begin
      return `NOP_INSTR;
    end
    return rowInstr[idx];
  endfunction

  ////////////////////
  // Clock and fetch model
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Full level is steady from edge to edge, so acceptance is known here
  always @(negedge clk) begin
    if (reset) begin
      pcNow    = BasePc;
      accepted = 1'b0;
    end else begin
      if (redirect) begin
        pcNow = redirectPc;
      end else if (accepted) begin
        pcNow = pcNow + 4;
      end
      fetchStall  = ($urandom % 4) == 0;
      decodeStall = ($urandom % 4) == 0;
      fetchPc     = pcNow;
      fetchInstr  = instrAt(pcNow);
      // Pair written during a flush is wiped, so present it again
      accepted = !redirect && !bufferFull && !fetchStall;
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int cycles;
    void'($urandom(32'h8d0f));
    reset       = 1'b1;
    fetchPc     = BasePc;
    fetchInstr  = `NOP_INSTR;
    fetchStall  = 1'b0;
    decodeStall = 1'b0;
    report      = 1'b0;
    waitErrors  = 0;
    otherErrors = 0;
    buildTable();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset <= 1'b0;

    cycles = 0;
    while (!done && cycles < WaitLimit) begin
      @(posedge clk);
      cycles++;
    end
    if (!done) begin
      $display("Timeout: the last table event did not arrive within %0d cycles", WaitLimit);
      waitErrors++;
    end

    // Extra cycles catch duplicated write-backs
    repeat (20) @(posedge clk);
    otherErrors = waitErrors + u_dut.u_fetchBuffer.u_asserts.failCount;
    #1;
    report = 1'b1;
    #1;
    if (errorCount == 0 && otherErrors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+src
src/corePkg.sv
src/fetchBuffer.sv
src/decodeStage.sv
src/executeStage.sv
src/resultStage.sv
src/coreTop.sv
test/coreAsserts.sv
test/coreChecker.sv
test/coreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Isrc -f verilog.f \
    --top-module coreTb -o coreSim; then
  echo "Verilator build failed"
  exit 1
fi

# Keep counting assertion failures instead of stopping on the first one
output=$(./obj_dir/coreSim +verilator+error+limit+1000)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1
